/* include/tag_alloc_config.svh */
// tag allocator configuration
// sizes shared by the packages, the RTL and the checkers

`ifndef TAG_ALLOC_CONFIG_SVH
`define TAG_ALLOC_CONFIG_SVH

// number of tags in the free list
`define TA_NUM_TAGS 16

// bits needed to index one tag
`define TA_TAG_W 4

// number of requesters feeding the scheduler
`define TA_NUM_REQ 4

// bits needed to index one requester
`define TA_REQ_W 2

`endif

/* design/tag_pkg.sv */
// tag-side types for the tag allocator
// tag index, free-tag occupancy and the release record

`include "tag_alloc_config.svh"

package tag_pkg;

   // one tag index
   typedef logic [`TA_TAG_W-1:0] tag_t;

   // one extra bit so the full tag count fits
   typedef logic [`TA_TAG_W:0] count_t;

   // a requester hands one tag back
   typedef struct packed {
      logic                 valid;
      logic [`TA_REQ_W-1:0] req_id;
      tag_t                 tag;
   } release_t;

endpackage

/* design/req_pkg.sv */
// requester-side types for the tag allocator
// request levels, requester index and the grant record

`include "tag_alloc_config.svh"

package req_pkg;

   // one level request bit per requester
   typedef logic [`TA_NUM_REQ-1:0] req_vec_t;

   // requester index
   typedef logic [`TA_REQ_W-1:0] req_id_t;

   // tag handed to the picked requester
   typedef struct packed {
      logic                 valid;
      req_id_t              req_id;
      logic [`TA_TAG_W-1:0] tag;
   } grant_t;

endpackage

/* design/rr_sched.sv */
// round-robin scheduler
// picks the next requester above the last grant, wrapping around

`timescale 1ns/1ps

`include "tag_alloc_config.svh"

module rr_sched (
   input  logic              clk,
   input  logic              rstn,
   input  req_pkg::req_vec_t req,
   input  logic              advance,
   output req_pkg::req_id_t  pick,
   output logic              any
);

   req_pkg::req_id_t         last_id;
   logic [2*`TA_NUM_REQ-1:0] dbl_req;

   assign any = |req;

   // lower half only keeps requesters above the last grant,
   // upper half is the full vector and catches the wrap
   always_comb begin
      for (int i = 0; i < `TA_NUM_REQ; i++) begin
         dbl_req[i]               = req[i] & (i > int'(last_id));
         dbl_req[`TA_NUM_REQ + i] = req[i];
      end
   end

   // lowest set bit of the doubled vector, 0 when nothing is set
   // both halves share the low index bits, so they fold onto one id
   always_comb begin
      pick = '0;
      for (int i = 2*`TA_NUM_REQ-1; i >= 0; i--) begin
         if (dbl_req[i]) begin
            pick = req_pkg::req_id_t'(i);
         end
      end
   end

   // pointer moves only when the pick is actually served
   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_id <= '0;
      end else if (advance) begin
         last_id <= pick;
      end
   end

endmodule

/* design/free_list.sv */
// free tag list
// FWFT circular queue that starts out holding every tag in order

`timescale 1ns/1ps

`include "tag_alloc_config.svh"

module free_list (
   input  logic            clk,
   input  logic            rstn,
   input  logic            push,
   input  tag_pkg::tag_t   push_tag,
   input  logic            pop,
   output tag_pkg::tag_t   head,
   output logic            empty,
   output tag_pkg::count_t count
);

   // extra msb on the pointers separates full from empty
   localparam int PTR_W = `TA_TAG_W + 1;

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] next_rd_ptr;
   tag_pkg::tag_t    mem [`TA_NUM_TAGS];
   logic             collide;

   assign empty       = (wr_ptr == rd_ptr);
   assign next_rd_ptr = rd_ptr + PTR_W'(pop);

   // push into the very slot the head is fetched from
   assign collide = push & (wr_ptr == next_rd_ptr);

   // write pointer starts a full lap ahead, list is full after reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= PTR_W'(`TA_NUM_TAGS);
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
      end
   end

   // storage is preloaded with tags 0 upward so reset restores the list
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < `TA_NUM_TAGS; i++) begin
            mem[i] <= tag_pkg::tag_t'(i);
         end
      end else if (push) begin
         mem[wr_ptr[`TA_TAG_W-1:0]] <= push_tag;
      end
   end

   // head is fetched one cycle ahead from the next read slot
   always_ff @(posedge clk) begin
      if (!rstn) begin
         // tag 0 is first in line
         head <= '0;
      end else if (collide) begin
         head <= push_tag;
      end else begin
         head <= mem[next_rd_ptr[`TA_TAG_W-1:0]];
      end
   end

   // occupancy, unchanged when a push and a pop meet
   always_ff @(posedge clk) begin
      if (!rstn) begin
         count <= tag_pkg::count_t'(`TA_NUM_TAGS);
      end else if (push && !pop) begin
         count <= count + tag_pkg::count_t'(1);
      end else if (pop && !push) begin
         count <= count - tag_pkg::count_t'(1);
      end
   end

endmodule

/* design/owner_table.sv */
// tag owner table
// records which requester holds each tag and screens releases

`timescale 1ns/1ps

`include "tag_alloc_config.svh"

module owner_table (
   input  logic              clk,
   input  logic              rstn,
   input  req_pkg::grant_t   grant,
   input  tag_pkg::release_t release_in,
   output logic              release_ok,
   output logic              release_error
);

   logic [`TA_NUM_TAGS-1:0] held;
   req_pkg::req_id_t        owner [`TA_NUM_TAGS];
   logic                    tag_held;
   logic                    owner_match;

   assign tag_held    = held[release_in.tag];
   assign owner_match = (owner[release_in.tag] == release_in.req_id);

   // only the current holder may hand a tag back
   assign release_ok = release_in.valid & tag_held & owner_match;

   // a granted tag comes from the free list, so it never equals
   // the tag of a legal release in the same cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= '0;
      end else begin
         if (release_ok) begin
            held[release_in.tag] <= 1'b0;
         end
         if (grant.valid) begin
            held[grant.tag] <= 1'b1;
         end
      end
   end

   // owner id only means something while the held bit is set
   always_ff @(posedge clk) begin
      if (grant.valid) begin
         owner[grant.tag] <= grant.req_id;
      end
   end

   // free tag or wrong owner, flagged for one cycle after the attempt
   always_ff @(posedge clk) begin
      if (!rstn) begin
         release_error <= 1'b0;
      end else begin
         release_error <= release_in.valid & ~release_ok;
      end
   end

endmodule

/* design/tag_alloc_top.sv */
// tag allocator top level
// round-robin grants from a free list, releases checked against owners

`timescale 1ns/1ps

module tag_alloc_top (
   input  logic              clk,
   input  logic              rstn,
   input  req_pkg::req_vec_t req,
   input  tag_pkg::release_t release_in,
   output req_pkg::grant_t   grant,
   output tag_pkg::count_t   free_count,
   output logic              release_error
);

   req_pkg::req_id_t pick;
   logic             any;
   tag_pkg::tag_t    head;
   logic             empty;
   logic             release_ok;

   // zero-latency grant, the head tag goes straight to the pick
   always_comb begin
      grant.valid  = any & ~empty;
      grant.req_id = pick;
      grant.tag    = head;
   end

   rr_sched u_rr_sched (
      .clk     (clk),
      .rstn    (rstn),
      .req     (req),
      .advance (grant.valid),
      .pick    (pick),
      .any     (any)
   );

   // legal releases go back to the tail of the list
   free_list u_free_list (
      .clk      (clk),
      .rstn     (rstn),
      .push     (release_ok),
      .push_tag (release_in.tag),
      .pop      (grant.valid),
      .head     (head),
      .empty    (empty),
      .count    (free_count)
   );

   owner_table u_owner_table (
      .clk           (clk),
      .rstn          (rstn),
      .grant         (grant),
      .release_in    (release_in),
      .release_ok    (release_ok),
      .release_error (release_error)
   );

endmodule

/* verification/tb_clock_gen.sv */
// clock and reset source for the tag allocator testbench
// free-running clock, reset held low for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2);
         clk = ~clk;
      end
   end

   // released just after an edge, the next edge sees it cleanly
   initial begin
      rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstn = 1'b1;
   end

endmodule

/* verification/tag_alloc_assertions.sv */
// protocol checks for the tag allocator
// bound to the top level, watches grants, releases and the free count

`timescale 1ns/1ps

`include "tag_alloc_config.svh"

module tag_alloc_assertions (
   input logic              clk,
   input logic              rstn,
   input req_pkg::req_vec_t req,
   input tag_pkg::release_t release_in,
   input req_pkg::grant_t   grant,
   input tag_pkg::count_t   free_count,
   input logic              release_error,
   input logic              empty
);

   int unsigned fail_count = 0;

   // a grant only serves an active request
   a_grant_has_req : assert property (@(posedge clk) disable iff (!rstn)
      grant.valid |-> req[grant.req_id])
      else begin
         fail_count++;
         $error("grant issued to a requester that is not requesting");
      end

   // zero latency, a waiting request is served whenever free tags are counted
   a_grant_when_ready : assert property (@(posedge clk) disable iff (!rstn)
      grant.valid == ((|req) && (free_count != 0)))
      else begin
         fail_count++;
         $error("grant valid does not follow the requests and the free count");
      end

   // empty flag and occupancy agree, count never exceeds the tag total
   a_count_consistent : assert property (@(posedge clk) disable iff (!rstn)
      ((free_count == 0) == empty) && (free_count <= `TA_NUM_TAGS))
      else begin
         fail_count++;
         $error("free count disagrees with the empty flag or is out of range");
      end

   // one up per accepted release, one down per grant
   // a release counts as accepted when no error pulse follows it
   a_count_step : assert property (@(posedge clk) disable iff (!rstn)
      $past(rstn) |-> (free_count == $past(free_count)
                       + tag_pkg::count_t'($past(release_in.valid) && !release_error)
                       - tag_pkg::count_t'($past(grant.valid))))
      else begin
         fail_count++;
         $error("free count did not follow the grants and accepted releases");
      end

   // the head of the list is free, so handing it back is always illegal
   a_free_release_error : assert property (@(posedge clk) disable iff (!rstn)
      (release_in.valid && (free_count != 0) && (release_in.tag == grant.tag))
      |=> release_error)
      else begin
         fail_count++;
         $error("release of a free tag did not raise the error pulse");
      end

   // the error pulse answers a release one cycle earlier
   a_error_after_release : assert property (@(posedge clk) disable iff (!rstn)
      release_error |-> $past(release_in.valid))
      else begin
         fail_count++;
         $error("error pulse raised without a release in the cycle before");
      end

endmodule

/* verification/tb_tag_alloc.sv */
// tag allocator testbench
// drives requests and releases, checks grants against a model of the owned tags

`timescale 1ns/1ps

`include "tag_alloc_config.svh"

module tb_tag_alloc;

   localparam int     PERIOD_NS     = 8;
   localparam int     RESET_CYCLES  = 16;
   localparam int     FILL_CYCLES   = 25;
   localparam int     DIRECT_CYCLES = 16;
   localparam int     RANDOM_CYCLES = 1500;
   localparam int     DRAIN_CYCLES  = 4;
   localparam int     TOTAL_CYCLES  = RESET_CYCLES + FILL_CYCLES + DIRECT_CYCLES +
                                      RANDOM_CYCLES + DRAIN_CYCLES;
   localparam longint TIMEOUT_NS    = longint'(TOTAL_CYCLES) * PERIOD_NS * 2;
   localparam int     SEED          = 32'h9cbd;

   logic              clk;
   logic              rstn;
   req_pkg::req_vec_t req;
   tag_pkg::release_t release_in;
   req_pkg::grant_t   grant;
   tag_pkg::count_t   free_count;
   logic              release_error;

   // model of owned tags and of the free list order
   logic              held [`TA_NUM_TAGS];
   req_pkg::req_id_t  owner [`TA_NUM_TAGS];
   tag_pkg::tag_t     free_q [$];
   req_pkg::req_id_t  last_id;
   int                exp_count;
   logic              exp_error;
   int                checks;
   int                errors;
   bit                monitor_on;

   tb_clock_gen #(
      .PERIOD_NS    (PERIOD_NS),
      .RESET_CYCLES (RESET_CYCLES)
   ) u_clock_gen (
      .clk  (clk),
      .rstn (rstn)
   );

   tag_alloc_top u_tag_alloc_top (
      .clk           (clk),
      .rstn          (rstn),
      .req           (req),
      .release_in    (release_in),
      .grant         (grant),
      .free_count    (free_count),
      .release_error (release_error)
   );

   bind tag_alloc_top tag_alloc_assertions u_tag_alloc_assertions (
      .clk           (clk),
      .rstn          (rstn),
      .req           (req),
      .release_in    (release_in),
      .grant         (grant),
      .free_count    (free_count),
      .release_error (release_error),
      .empty         (empty)
   );

   // next requesting index above the last grant, wrapping around
   function automatic req_pkg::req_id_t next_requester(input req_pkg::req_vec_t r,
                                                       input req_pkg::req_id_t last);
      int idx;
      for (int step = 1; step <= `TA_NUM_REQ; step++) begin
         idx = (int'(last) + step) % `TA_NUM_REQ;
         if (r[idx]) begin
            return req_pkg::req_id_t'(idx);
         end
      end
      return '0;
   endfunction

   task automatic compare_value(input string name, input int got, input int expected);
      checks++;
      assert (got == expected) else begin
         errors++;
         $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t ns",
                  name, got, expected, $time);
      end
   endtask

   // one cycle of stimulus, applied just after the rising edge
   task automatic drive_cycle(input req_pkg::req_vec_t r, input logic rel_valid,
                              input req_pkg::req_id_t rel_id, input tag_pkg::tag_t rel_tag);
      @(posedge clk);
      #1;
      req               = r;
      release_in.valid  = rel_valid;
      release_in.req_id = rel_id;
      release_in.tag    = rel_tag;
   endtask

   // outputs are stable mid-cycle, model then steps to the next edge
   task automatic check_cycle();
      logic             exp_valid;
      logic             rel_legal;
      tag_pkg::tag_t    exp_tag;
      req_pkg::req_id_t exp_id;
      exp_valid = (req != '0) && (free_q.size() > 0);
      compare_value("grant.valid", grant.valid, exp_valid);
      compare_value("free_count", free_count, exp_count);
      compare_value("release_error", release_error, exp_error);
      // judged against the owners before this edge
      rel_legal = release_in.valid && held[release_in.tag] &&
                  (owner[release_in.tag] == release_in.req_id);
      exp_error = release_in.valid && !rel_legal;
      if (grant.valid && exp_valid) begin
         exp_tag = free_q.pop_front();
         exp_id  = next_requester(req, last_id);
         compare_value("grant.tag", grant.tag, exp_tag);
         compare_value("grant.req_id", grant.req_id, exp_id);
         checks++;
         assert (req[grant.req_id] && !held[grant.tag]) else begin
            errors++;
            $display("grant of tag 0x%0h went to an idle requester or a held tag", grant.tag);
         end
         held[exp_tag]  = 1'b1;
         owner[exp_tag] = exp_id;
         last_id        = exp_id;
         exp_count--;
      end
      if (rel_legal) begin
         held[release_in.tag] = 1'b0;
         free_q.push_back(release_in.tag);
         exp_count++;
      end
   endtask

   always @(negedge clk) begin
      if (monitor_on) begin
         check_cycle();
      end
   end

   initial begin
      req_pkg::req_vec_t rand_req;
      tag_pkg::tag_t     rand_tag;
      int                roll;
      int unsigned       assert_errors;
      void'($urandom(SEED));
      req        = '0;
      release_in = '0;
      for (int i = 0; i < `TA_NUM_TAGS; i++) begin
         held[i]  = 1'b0;
         owner[i] = '0;
         free_q.push_back(tag_pkg::tag_t'(i));
      end
      last_id    = '0;
      exp_count  = `TA_NUM_TAGS;
      exp_error  = 1'b0;
      checks     = 0;
      errors     = 0;
      monitor_on = 1'b0;

      @(posedge rstn);
      monitor_on = 1'b1;
      @(negedge clk);
      compare_value("free_count after reset", free_count, `TA_NUM_TAGS);
      compare_value("grant.valid after reset", grant.valid, 0);

      // every requester keeps asking, the list drains in tag order
      repeat (FILL_CYCLES - 1) drive_cycle(4'hf, 1'b0, '0, '0);
      @(negedge clk);
      compare_value("free_count when drained", free_count, 0);
      compare_value("grant.valid when drained", grant.valid, 0);

      // one legal release, the tag comes back the cycle after
      drive_cycle(4'hf, 1'b1, owner[5], 4'd5);
      drive_cycle(4'hf, 1'b0, '0, '0);
      @(negedge clk);
      compare_value("grant.valid after release", grant.valid, 1);
      compare_value("grant.tag after release", grant.tag, 5);

      // releases with no requests, then one alongside a grant
      drive_cycle(4'h0, 1'b1, owner[9], 4'd9);
      drive_cycle(4'h0, 1'b1, owner[3], 4'd3);
      drive_cycle(4'hf, 1'b1, owner[11], 4'd11);
      drive_cycle(4'h0, 1'b0, '0, '0);

      // free tag, then a held tag from the wrong requester
      drive_cycle(4'h0, 1'b1, '0, free_q[0]);
      drive_cycle(4'h0, 1'b1, owner[7] + 1'b1, 4'd7);
      drive_cycle(4'h0, 1'b0, '0, '0);
      drive_cycle(4'h0, 1'b0, '0, '0);

      for (int n = 0; n < RANDOM_CYCLES; n++) begin
         rand_req = req_pkg::req_vec_t'($urandom);
         rand_tag = tag_pkg::tag_t'($urandom);
         roll     = $urandom_range(9);
         if (roll < 5 && held[rand_tag]) begin
            drive_cycle(rand_req, 1'b1, owner[rand_tag], rand_tag);
         end else if (roll == 5) begin
            // usually illegal, the model decides
            drive_cycle(rand_req, 1'b1, req_pkg::req_id_t'($urandom), rand_tag);
         end else begin
            drive_cycle(rand_req, 1'b0, '0, '0);
         end
      end

      drive_cycle(4'h0, 1'b0, '0, '0);
      drive_cycle(4'h0, 1'b0, '0, '0);
      @(negedge clk);
      #1;
      monitor_on    = 1'b0;
      assert_errors = u_tag_alloc_top.u_tag_alloc_assertions.fail_count;
      $display("checks: %0d, check errors: %0d, assertion errors: %0d",
               checks, errors, assert_errors);
      if (errors == 0 && assert_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns before the tests completed", TIMEOUT_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+include
design/tag_pkg.sv
design/req_pkg.sv
design/rr_sched.sv
design/free_list.sv
design/owner_table.sv
design/tag_alloc_top.sv
verification/tb_clock_gen.sv
verification/tag_alloc_assertions.sv
verification/tb_tag_alloc.sv
